//--- files.f
+incdir+src
src/decodePkg.sv
src/control.sv
src/regFile.sv
src/decodeStage.sv
src/decodeTop.sv
testbench/decode_asserts.sv
testbench/decodeTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f files.f --top-module decodeTb -o decodeSim \
    > build.log 2>&1 \
    && (./obj_dir/decodeSim > sim.log 2>&1 || echo "Errors found" >> sim.log) \
    || { cat build.log; echo "Errors found" > sim.log; }
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

//--- testbench/decodeTb.sv
// Simulation top that drives random instructions and writebacks and checks every ID/EX output against an ISA model
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decodeTb
    import decodePkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 3000;

    logic   clk, rstN, instrValid, stall, flush, wbEn;
    dataT   instr, wbData;
    regIdxT wbReg;
    logic   exValid, exAluSel, exRegWrite, exMemEnable, exMemWr, exVal2Reg, exLink, exLbi;
    logic   exBranch, exJump, exRegJmp, exHalt, exSiic, exErr;
    opcodeT exAluOp;
    dataT   exImm, exRsData, exRtData;
    regIdxT exDestReg;

    dataT        shadow [`NUM_REGS];       // Architectural register contents
    logic        expValid;                 // Expected ID/EX contents
    opcodeT      expAluOp;
    logic [12:0] expFlags;                 // Same order as flagNames
    dataT        expImm, expRs, expRt;
    regIdxT      expDest;
    string       flagNames [13] = '{"exAluSel", "exRegWrite", "exMemEnable", "exMemWr",
        "exVal2Reg", "exLink", "exLbi", "exBranch", "exJump", "exRegJmp", "exHalt",
        "exSiic", "exErr"};

    decodeTop decodeTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Whole run plus some slack
    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout, the stimulus loop did not complete");
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic compareOutputs();
        logic [12:0] dutFlags;
        dutFlags = {exAluSel, exRegWrite, exMemEnable, exMemWr, exVal2Reg, exLink, exLbi,
                    exBranch, exJump, exRegJmp, exHalt, exSiic, exErr};
        checkValue("exValid", 16'(exValid), 16'(expValid));
        checkValue("exAluOp", 16'(exAluOp), 16'(expAluOp));
        for (int i = 0; i < 13; i++) begin
            checkValue(flagNames[i], 16'(dutFlags[12 - i]), 16'(expFlags[12 - i]));
        end
        checkValue("exImm", exImm, expImm);
        checkValue("exRsData", exRsData, expRs);
        checkValue("exRtData", exRtData, expRt);
        checkValue("exDestReg", 16'(exDestReg), 16'(expDest));
    endtask

    // Expected ID/EX contents after the next edge given the inputs now held
    task automatic predictEdge();
        opcodeT      op;
        opcodeT      aluOp;
        logic        isSys, isArith, isMem, isStu, isRfmt, isBr, isLbi, isSlbi, isJmp;
        logic [12:0] flags;
        int          immBits;
        logic        immSign;
        dataT        mask;
        dataT        imm;
        regIdxT      dest;
        op      = instr[15:11];
        isSys   = (op[4:2] == 3'b000);                          // HALT NOP SIIC RTI
        isArith = (op[4:2] == 3'b010) || (op[4:2] == 3'b101);
        isMem   = (op[4:1] == 4'b1000);                         // ST LD
        isStu   = (op == 5'b10011);
        isRfmt  = (op == 5'b11001) || (op[4:1] == 4'b1101) || (op[4:2] == 3'b111);
        isBr    = (op[4:2] == 3'b011);
        isLbi   = (op == 5'b11000);
        isSlbi  = (op == 5'b10010);
        isJmp   = (op[4:2] == 3'b001);                          // J JR JAL JALR
        aluOp   = (isSys && op[1:0] == 2'b11) ? 5'b00001 : op; // RTI as NOP
        flags = {isSys | isArith | isMem | isStu | isLbi | isSlbi | isJmp,
                 isArith | (isMem & op[0]) | isStu | isRfmt | isLbi | isSlbi | (isJmp & op[1]),
                 isMem | isStu,
                 (isMem & ~op[0]) | isStu,
                 isMem & op[0],
                 isJmp & op[1],
                 isLbi,
                 isBr,
                 isJmp & ~op[0],
                 isJmp & op[0],
                 isSys & (op[1:0] == 2'b00),
                 isSys & (op[1:0] == 2'b10),
                 isArith & op[1]};
        immBits = (isBr || isLbi || isSlbi || (isJmp && op[0])) ? 8 : (isJmp ? 11 : 5);
        immSign = isSys | (isArith & ~op[1]) | isMem | isStu | isBr | isLbi | isJmp;
        mask    = dataT'((32'd1 << immBits) - 32'd1);
        imm     = instr & mask;
        if (immSign && instr[immBits - 1]) begin
            imm = imm | ~mask;                                  // Copy the field MSB upward
        end
        dest = isRfmt ? instr[4:2] : isJmp ? regIdxT'(`LINK_REG) :
               (isSys | isArith | isMem) ? instr[7:5] : instr[10:8];
        if (flush) begin
            expValid = 1'b0;                                    // Flush wins over stall
            expAluOp = '0;
            expFlags = '0;
        end else if (!stall) begin
            expValid = instrValid;
            expAluOp = instrValid ? aluOp : '0;
            expFlags = instrValid ? flags : '0;
        end
        if (!stall) begin
            expImm  = imm;
            expRs   = (wbEn && wbReg == instr[10:8]) ? wbData : shadow[instr[10:8]];
            expRt   = (wbEn && wbReg == instr[7:5]) ? wbData : shadow[instr[7:5]];
            expDest = dest;
        end
        if (wbEn) begin
            shadow[wbReg] = wbData;                             // Writes ignore stall
        end
    endtask

    initial begin
        dataT        nextInstr;
        void'($urandom(32'hc05e));
        instr      = '0;
        instrValid = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        wbEn       = 1'b0;
        wbReg      = '0;
        wbData     = '0;
        rstN       = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        expValid = 1'b0;
        expAluOp = '0;
        expFlags = '0;
        expImm   = '0;
        expRs    = '0;
        expRt    = '0;
        expDest  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            nextInstr   = dataT'($urandom);
            instr      <= nextInstr;
            instrValid <= ($urandom % 4) != 0;
            stall      <= ($urandom % 5) == 0;
            flush      <= ($urandom % 10) == 0;
            wbEn       <= ($urandom % 2) == 0;
            wbReg      <= ($urandom % 3 == 0) ? nextInstr[10:8] : regIdxT'($urandom); // Bypass
            wbData     <= dataT'($urandom);
            @(negedge clk);
            compareOutputs();                                   // Result of the edge just passed
            predictEdge();
        end
        if (decodeTop_i.decodeAsserts_i.failCount != 0) begin
            $display("Assertion checker counted %0d failures", decodeTop_i.decodeAsserts_i.failCount);
            $display("Errors found");
            $fatal(1, "Assertion failures");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/decode_asserts.sv
// Concurrent checks on reset, flush and stall behavior of the ID/EX outputs, bound into decodeTop
`timescale 1ns/1ps
`default_nettype none

module decodeAsserts (
    input logic        clk,
    input logic        rstN,
    input logic        stall,
    input logic        flush,
    input logic        exValid,
    input logic [69:0] exBundle     // Every ex output side by side
);

    int failCount = 0;              // Read by the testbench at the end

    // Empty through reset and on the edge that releases it
    resetEmpty: assert property (@(posedge clk) !rstN |=> !exValid)
        else begin
            failCount++;
            $error("exValid high after a reset cycle");
        end

    flushEmpty: assert property (@(posedge clk) disable iff (!rstN) flush |=> !exValid)
        else begin
            failCount++;
            $error("exValid high after a flush");
        end

    // Held stage keeps data and control alike
    stallHold: assert property (@(posedge clk) disable iff (!rstN)
        (stall && !flush) |=> $stable(exBundle))
        else begin
            failCount++;
            $error("ex outputs changed across a stall");
        end

endmodule

bind decodeTop decodeAsserts decodeAsserts_i (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .flush    (flush),
    .exValid  (exValid),
    .exBundle ({exAluOp, exImm, exRsData, exRtData, exDestReg, exAluSel, exRegWrite,
                exMemEnable, exMemWr, exVal2Reg, exLink, exLbi, exBranch, exJump,
                exRegJmp, exHalt, exSiic, exErr, exValid})
);

`default_nettype wire

//--- src/decodeTop.sv
// Decode stage top level, connects the opcode decoder and register file to the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeTop
    import decodePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  dataT   instr,
    input  logic   instrValid,
    input  logic   stall,
    input  logic   flush,
    input  logic   wbEn,
    input  regIdxT wbReg,
    input  dataT   wbData,
    output logic   exValid,
    output opcodeT exAluOp,
    output logic   exAluSel,
    output dataT   exImm,
    output dataT   exRsData,
    output dataT   exRtData,
    output regIdxT exDestReg,
    output logic   exRegWrite,
    output logic   exMemEnable,
    output logic   exMemWr,
    output logic   exVal2Reg,
    output logic   exLink,
    output logic   exLbi,
    output logic   exBranch,
    output logic   exJump,
    output logic   exRegJmp,
    output logic   exHalt,
    output logic   exSiic,
    output logic   exErr
);

    // Raw decoder levels
    opcodeT  aluOp;
    logic    aluSel, regWrite, memEnable, memWr, val2Reg;
    logic    link, lbi, branch, jump, regJmp;
    logic    halt, siic, err;
    immSelT  immSel;
    destSelT destSel;

    // Register read data
    dataT    rsData, rtData;

    control control_i (
        .opcode    (instr[15:11]),   // Opcode field
        .aluOp     (aluOp),     .aluSel  (aluSel),  .regWrite (regWrite),
        .memEnable (memEnable), .memWr   (memWr),   .val2Reg  (val2Reg),
        .link      (link),      .lbi     (lbi),     .branch   (branch),
        .jump      (jump),      .regJmp  (regJmp),  .halt     (halt),
        .siic      (siic),      .err     (err),
        .immSel    (immSel),    .destSel (destSel)
    );

    regFile regFile_i (
        .clk    (clk),          .rstN   (rstN),
        .rsIdx  (instr[10:8]),       // Rs field
        .rtIdx  (instr[7:5]),        // Rt field
        .wbEn   (wbEn),         .wbReg  (wbReg),    .wbData (wbData),
        .rsData (rsData),       .rtData (rtData)
    );

    decodeStage decodeStage_i (
        .clk         (clk),         .rstN       (rstN),
        .instr       (instr),       .instrValid (instrValid),
        .stall       (stall),       .flush      (flush),
        .aluOp       (aluOp),       .aluSel     (aluSel),     .regWrite  (regWrite),
        .memEnable   (memEnable),   .memWr      (memWr),      .val2Reg   (val2Reg),
        .link        (link),        .lbi        (lbi),        .branch    (branch),
        .jump        (jump),        .regJmp     (regJmp),     .halt      (halt),
        .siic        (siic),        .err        (err),
        .immSel      (immSel),      .destSel    (destSel),
        .rsData      (rsData),      .rtData     (rtData),
        .exValid     (exValid),     .exAluOp    (exAluOp),    .exAluSel  (exAluSel),
        .exImm       (exImm),       .exRsData   (exRsData),   .exRtData  (exRtData),
        .exDestReg   (exDestReg),   .exRegWrite (exRegWrite),
        .exMemEnable (exMemEnable), .exMemWr    (exMemWr),    .exVal2Reg (exVal2Reg),
        .exLink      (exLink),      .exLbi      (exLbi),      .exBranch  (exBranch),
        .exJump      (exJump),      .exRegJmp   (exRegJmp),   .exHalt    (exHalt),
        .exSiic      (exSiic),      .exErr      (exErr)
    );

endmodule

`default_nettype wire

//--- src/decodeStage.sv
// ID/EX pipeline register with immediate extension and destination select that decodeTop feeds from the decoder and register file
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decodeStage
    import decodePkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  dataT    instr,        // Instruction being decoded
    input  logic    instrValid,   // Instruction present this cycle
    input  logic    stall,        // Hold the ID/EX register
    input  logic    flush,        // Kill the ID/EX contents
    input  opcodeT  aluOp,
    input  logic    aluSel,
    input  logic    regWrite,
    input  logic    memEnable,
    input  logic    memWr,
    input  logic    val2Reg,
    input  logic    link,
    input  logic    lbi,
    input  logic    branch,
    input  logic    jump,
    input  logic    regJmp,
    input  logic    halt,
    input  logic    siic,
    input  logic    err,
    input  immSelT  immSel,
    input  destSelT destSel,
    input  dataT    rsData,       // Rs read data
    input  dataT    rtData,       // Rt read data
    output logic    exValid,
    output opcodeT  exAluOp,
    output logic    exAluSel,
    output dataT    exImm,
    output dataT    exRsData,
    output dataT    exRtData,
    output regIdxT  exDestReg,
    output logic    exRegWrite,
    output logic    exMemEnable,
    output logic    exMemWr,
    output logic    exVal2Reg,
    output logic    exLink,
    output logic    exLbi,
    output logic    exBranch,
    output logic    exJump,
    output logic    exRegJmp,
    output logic    exHalt,
    output logic    exSiic,
    output logic    exErr
);

    stageStateT state;            // ID/EX occupancy
    dataT       immExt;           // Extended immediate
    regIdxT     destIdx;          // Chosen destination

    // Fill bit is the field MSB only when sign extension is asked for
    always_comb begin
        case (immSel[1:0])
            2'b00:   immExt = {{(`DATA_W-5){immSel[2] & instr[4]}}, instr[4:0]};
            2'b01:   immExt = {{(`DATA_W-8){immSel[2] & instr[7]}}, instr[7:0]};
            2'b10:   immExt = {{(`DATA_W-11){immSel[2] & instr[10]}}, instr[10:0]};
            default: immExt = '0;                     // No 16-bit field
        endcase
    end

    always_comb begin
        case (destSel)
            DEST_RS:   destIdx = instr[10:8];         // Rs
            DEST_RD_R: destIdx = instr[4:2];          // R-format Rd
            DEST_LINK: destIdx = regIdxT'(`LINK_REG); // R7 for links
            default:   destIdx = instr[7:5];          // I-format Rd
        endcase
    end

    assign exValid = (state == FULL);                  // Valid straight from occupancy flop

    // Control side loads a bubble as all-zero flags
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= EMPTY;
            exAluOp     <= '0;
            {exAluSel, exRegWrite, exMemEnable, exMemWr, exVal2Reg} <= '0;
            {exLink, exLbi, exBranch, exJump, exRegJmp} <= '0;
            {exHalt, exSiic, exErr} <= '0;
        end else if (flush) begin
            state       <= EMPTY;                     // Flush wins over stall
            exAluOp     <= '0;
            {exAluSel, exRegWrite, exMemEnable, exMemWr, exVal2Reg} <= '0;
            {exLink, exLbi, exBranch, exJump, exRegJmp} <= '0;
            {exHalt, exSiic, exErr} <= '0;
        end else if (!stall) begin
            state       <= instrValid ? FULL : EMPTY; // Take or drop a slot
            exAluOp     <= instrValid ? aluOp : '0;
            exAluSel    <= aluSel    & instrValid;
            exRegWrite  <= regWrite  & instrValid;
            exMemEnable <= memEnable & instrValid;
            exMemWr     <= memWr     & instrValid;
            exVal2Reg   <= val2Reg   & instrValid;
            exLink      <= link      & instrValid;
            exLbi       <= lbi       & instrValid;
            exBranch    <= branch    & instrValid;
            exJump      <= jump      & instrValid;
            exRegJmp    <= regJmp    & instrValid;
            exHalt      <= halt      & instrValid;
            exSiic      <= siic      & instrValid;
            exErr       <= err       & instrValid;
        end
    end

    // Data side follows the load enable only
    always_ff @(posedge clk) begin
        if (!stall) begin
            exImm     <= immExt;
            exRsData  <= rsData;
            exRtData  <= rtData;
            exDestReg <= destIdx;
        end
    end

endmodule

`default_nettype wire

//--- src/regFile.sv
// Eight-entry register file, two combinational read ports with write bypass and one clocked write
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module regFile
    import decodePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rsIdx,    // First source register
    input  regIdxT rtIdx,    // Second source register
    input  logic   wbEn,     // Writeback strobe
    input  regIdxT wbReg,    // Writeback register
    input  dataT   wbData,   // Writeback value
    output dataT   rsData,   // Rs contents
    output dataT   rtData    // Rt contents
);

    dataT regs [`NUM_REGS];  // Register storage

    // Write port, whole file cleared on reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;           // All registers read zero
            end
        end else if (wbEn) begin
            regs[wbReg] <= wbData;       // Commit writeback
        end
    end

    // Same-cycle write is forwarded so the reader sees the new value
    always_comb begin
        if (wbEn && (wbReg == rsIdx)) begin
            rsData = wbData;             // Bypass to Rs port
        end else begin
            rsData = regs[rsIdx];        // Stored value
        end
    end

    always_comb begin
        if (wbEn && (wbReg == rtIdx)) begin
            rtData = wbData;             // Bypass to Rt port
        end else begin
            rtData = regs[rtIdx];        // Stored value
        end
    end

endmodule

`default_nettype wire

//--- src/control.sv
// Combinational opcode decoder, turns the five opcode bits into the control levels of the stage
`timescale 1ns/1ps
`default_nettype none

module control
    import decodePkg::*;
(
    input  opcodeT  opcode,     // Top bits of the instruction
    output opcodeT  aluOp,      // ALU operation code
    output logic    aluSel,     // Immediate as ALU operand B
    output logic    regWrite,   // Write the destination register
    output logic    memEnable,  // Data memory access
    output logic    memWr,      // Data memory write
    output logic    val2Reg,    // Writeback from memory, not ALU
    output logic    link,       // Save return address
    output logic    lbi,        // Load byte immediate
    output logic    branch,     // Conditional branch
    output logic    jump,       // PC relative jump
    output logic    regJmp,     // Jump from Rs plus immediate
    output logic    halt,       // Stop issuing
    output logic    siic,       // Software interrupt
    output logic    err,        // Illegal encoding
    output immSelT  immSel,     // Immediate size and extension
    output destSelT destSel     // Destination register source
);

    always_comb begin
        // Defaults, every pattern below overrides only what it needs
        aluOp     = opcode;      // Pass opcode through
        aluSel    = 1'b0;        // Register operand
        regWrite  = 1'b0;        // No register write
        memEnable = 1'b0;        // No memory access
        memWr     = 1'b0;        // No memory write
        val2Reg   = 1'b0;        // ALU result to register
        link      = 1'b0;        // No link
        lbi       = 1'b0;        // No LBI
        branch    = 1'b0;        // No branch
        jump      = 1'b0;        // No jump
        regJmp    = 1'b0;        // No register jump
        halt      = 1'b0;        // Keep running
        siic      = 1'b0;        // No interrupt
        err       = 1'b0;        // Legal
        immSel    = IMM_ZEXT5;   // Zero extend 5 bits
        destSel   = DEST_RS;     // Rs as destination

        casez (opcode)
            5'b000??: begin                  // HALT, NOP, SIIC, RTI
                aluSel  = 1'b1;              // Immediate operand
                destSel = DEST_RD_I;         // I-format Rd
                immSel  = IMM_SEXT5;         // Sign extend 5 bits
                case (opcode[1:0])
                    2'b00:   halt  = 1'b1;   // HALT
                    2'b10:   siic  = 1'b1;   // SIIC, flag only
                    2'b11:   aluOp = 5'b00001; // RTI runs as NOP in the ALU
                    default: halt  = 1'b0;   // NOP
                endcase
            end

            5'b010??, 5'b101??: begin        // I-format 1 arithmetic and shifts
                regWrite = 1'b1;             // Result to Rd
                aluSel   = 1'b1;             // Immediate operand
                destSel  = DEST_RD_I;        // I-format Rd
                if (!opcode[1]) begin
                    immSel = IMM_SEXT5;      // Sign extend 5 bits
                end else begin
                    err = 1'b1;              // Encoding reserved here
                end
            end

            5'b1000?: begin                  // ST and LD
                aluSel    = 1'b1;            // Address is Rs plus immediate
                memEnable = 1'b1;            // Memory access
                destSel   = DEST_RD_I;       // I-format Rd
                immSel    = IMM_SEXT5;       // Sign extend 5 bits
                if (!opcode[0]) begin
                    memWr = 1'b1;            // ST, Rd to memory
                end else begin
                    val2Reg  = 1'b1;         // LD, memory data back
                    regWrite = 1'b1;         // LD writes Rd
                end
            end

            5'b10011: begin                  // STU, store and update Rs
                aluSel    = 1'b1;            // Address is Rs plus immediate
                regWrite  = 1'b1;            // Updated address to Rs
                memWr     = 1'b1;            // Store
                memEnable = 1'b1;            // Memory access
                immSel    = IMM_SEXT5;       // Sign extend 5 bits
                destSel   = DEST_RS;         // Rs gets the new address
            end

            5'b11001, 5'b1101?, 5'b111??: begin // R-format, LBI excluded
                destSel  = DEST_RD_R;        // R-format Rd
                regWrite = 1'b1;             // Result to Rd
            end

            5'b011??: begin                  // BEQZ, BNEZ, BLTZ, BGEZ
                immSel = IMM_SEXT8;          // Sign extend 8 bits
                branch = 1'b1;               // Condition from Rs
            end

            5'b11000: begin                  // LBI, Rs gets the immediate
                aluSel   = 1'b1;             // Immediate operand
                regWrite = 1'b1;             // Write Rs
                immSel   = IMM_SEXT8;        // Sign extend 8 bits
                lbi      = 1'b1;             // Bypass ALU result select
            end

            5'b10010: begin                  // SLBI, shift Rs and merge byte
                aluSel   = 1'b1;             // Immediate operand
                regWrite = 1'b1;             // Write Rs
                immSel   = IMM_ZEXT8;        // Zero extend 8 bits
            end

            5'b001??: begin                  // J, JAL, JR, JALR
                aluSel  = 1'b1;              // Immediate used for target
                destSel = DEST_LINK;         // Return address to R7
                if (!opcode[0]) begin
                    jump   = 1'b1;           // PC relative displacement
                    immSel = IMM_SEXT11;     // Sign extend 11 bits
                end else begin
                    regJmp = 1'b1;           // Rs plus immediate
                    immSel = IMM_SEXT8;      // Sign extend 8 bits
                end
                link     = opcode[1];        // JAL and JALR link
                regWrite = opcode[1];        // Only linking forms write R7
            end

            default: begin
                err = 1'b0;                  // Unlisted opcodes keep defaults
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/decodePkg.sv
// Shared types and select codes of the decode stage, imported by every RTL module
`default_nettype none

`include "decode_config.svh"

package decodePkg;

    typedef logic [`DATA_W-1:0]    dataT;    // One data word
    typedef logic [`REG_IDX_W-1:0] regIdxT;  // Register number
    typedef logic [`OPCODE_W-1:0]  opcodeT;  // Opcode, also the ALU operation code

    // Sign flag on top, field size below
    typedef logic [2:0] immSelT;

    // Destination register source
    typedef logic [1:0] destSelT;

    // Occupancy of the ID/EX register
    typedef enum logic {
        EMPTY = 1'b0,  // Bubble held
        FULL  = 1'b1   // Live instruction held
    } stageStateT;

    localparam immSelT IMM_ZEXT5  = 3'b000;  // Zero extend 5 bits
    localparam immSelT IMM_ZEXT8  = 3'b001;  // Zero extend 8 bits
    localparam immSelT IMM_SEXT5  = 3'b100;  // Sign extend 5 bits
    localparam immSelT IMM_SEXT8  = 3'b101;  // Sign extend 8 bits
    localparam immSelT IMM_SEXT11 = 3'b110;  // Sign extend 11 bits

    localparam destSelT DEST_RS   = 2'b00;   // Rs field
    localparam destSelT DEST_RD_R = 2'b01;   // R-format Rd
    localparam destSelT DEST_LINK = 2'b10;   // Link register
    localparam destSelT DEST_RD_I = 2'b11;   // I-format Rd

endpackage

`default_nettype wire

//--- src/decode_config.svh
// Width and size constants for the decode stage, included by the package and the RTL modules
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Register and data word width
`define DATA_W 16

// Register index width
`define REG_IDX_W 3

// Number of architectural registers
`define NUM_REGS 8

// Opcode field width, top bits of the instruction
`define OPCODE_W 5

// Register written by jump-and-link
`define LINK_REG 7

`endif
